//--- flist.f
src/isaPkg.sv
src/corePkg.sv
src/fetchStage.sv
src/registerFile.sv
src/hazardUnit.sv
src/decodeStage.sv
src/executeStage.sv
src/memoryStage.sv
src/pipelineCore.sv
dv/pipelineCore_checker.sv
dv/pipelineCoreTb.sv

//--- Bender.yml
package:
  name: pipeline_core

sources:
  - files:
      - src/isaPkg.sv
      - src/corePkg.sv
      - src/fetchStage.sv
      - src/registerFile.sv
      - src/hazardUnit.sv
      - src/decodeStage.sv
      - src/executeStage.sv
      - src/memoryStage.sv
      - src/pipelineCore.sv
  - target: test
    files:
      - dv/pipelineCore_checker.sv
      - dv/pipelineCoreTb.sv

//--- dv/pipelineCoreTb.sv
`timescale 1ns/1ns
`default_nettype none

module pipelineCoreTb;

    localparam int clkPeriod     = 40;
    localparam int resetCycles   = 8;
    localparam int romDepth      = 64;
    localparam int progLen       = 31;
    localparam int loopIdx       = 30;                 // Self-loop jump
    localparam int settleCycles  = 12;                 // Watch the loop after the last write
    localparam int timeoutCycles = progLen * 3 + 40;

    logic                              clk = 1'b0;
    logic                              rstN;
    logic [corePkg::dataWidth-1:0]     fetchAddr;
    isaPkg::instrWordT                 fetchInstr;
    logic                              wbEnable;
    logic [corePkg::regAddrWidth-1:0]  wbDest;
    logic [corePkg::dataWidth-1:0]     wbData;

    isaPkg::instrWordT                 rom [romDepth];
    logic [corePkg::dataWidth-1:0]     modelRegs [corePkg::numRegs];
    logic [corePkg::dataWidth-1:0]     modelMem [corePkg::dataMemDepth];
    logic [corePkg::regAddrWidth-1:0]  expDest [$];   // Expected writes, oldest first
    logic [corePkg::dataWidth-1:0]     expData [$];
    int                                seed;
    int                                errors;
    int                                wbChecked;

    always #(clkPeriod / 2) clk = ~clk;

    assign fetchInstr = rom[fetchAddr[7:2]];  // Same-cycle ROM reply

    pipelineCore i_pipelineCore (
        .clk        (clk),
        .rstN       (rstN),
        .fetchAddr  (fetchAddr),
        .fetchInstr (fetchInstr),
        .wbEnable   (wbEnable),
        .wbDest     (wbDest),
        .wbData     (wbData)
    );

    // ----------------------------------------
    // Instruction encoding
    // ----------------------------------------
    function automatic isaPkg::instrWordT aluWord(input isaPkg::aluFuncT func,
                                                  input logic [4:0] rd, rs, rt);
        isaPkg::instrWordT w;
        w          = '0;
        w.r.opcode = isaPkg::opAlu;
        w.r.rd     = rd;
        w.r.rs     = rs;
        w.r.rt     = rt;
        w.r.func   = func;
        return w;
    endfunction

    function automatic isaPkg::instrWordT immWord(input isaPkg::opcodeT op,
                                                  input logic [4:0] rd, rs,
                                                  input logic [15:0] imm);
        isaPkg::instrWordT w;
        w          = '0;
        w.i.opcode = op;
        w.i.rd     = rd;
        w.i.rs     = rs;
        w.i.imm    = imm;
        return w;
    endfunction

    function automatic isaPkg::instrWordT jumpWord(input logic [25:0] offset);
        isaPkg::instrWordT w;
        w                        = '0;
        w.i.opcode               = isaPkg::opJ;
        {w.i.rd, w.i.rs, w.i.imm} = offset;  // Offset in words
        return w;
    endfunction

    function automatic logic [15:0] randomImm();
        return 16'($random(seed));
    endfunction

    task automatic buildProgram();
        for (int i = 0; i < romDepth; i++) begin
            rom[i] = isaPkg::instrNop;  // Past the loop fetches read nops
        end
        rom[0]  = immWord(isaPkg::opAddi, 5'd1, 5'd0, randomImm());
        rom[1]  = immWord(isaPkg::opAddi, 5'd2, 5'd0, randomImm());
        rom[2]  = aluWord(isaPkg::aluAdd, 5'd3, 5'd1, 5'd2);   // Distances 2 and 1
        rom[3]  = aluWord(isaPkg::aluSub, 5'd4, 5'd3, 5'd1);   // r1 from WB
        rom[4]  = aluWord(isaPkg::aluXor, 5'd5, 5'd4, 5'd2);
        rom[5]  = aluWord(isaPkg::aluOr,  5'd6, 5'd5, 5'd3);
        rom[6]  = aluWord(isaPkg::aluAnd, 5'd6, 5'd6, 5'd4);   // Rewrites r6
        rom[7]  = aluWord(isaPkg::aluSlt, 5'd8, 5'd5, 5'd6);   // r6 in EX and MEM
        rom[8]  = immWord(isaPkg::opAddi, 5'd9, 5'd0, 16'h0040);
        rom[9]  = immWord(isaPkg::opSw,   5'd6, 5'd9, 16'h0000);  // rd holds store data
        rom[10] = immWord(isaPkg::opLw,   5'd10, 5'd9, 16'h0000);
        rom[11] = aluWord(isaPkg::aluAdd, 5'd11, 5'd10, 5'd1);    // Load-use by ALU
        rom[12] = immWord(isaPkg::opLw,   5'd12, 5'd9, 16'h0000);
        rom[13] = immWord(isaPkg::opBeqz, 5'd0, 5'd12, 16'd2);    // Load-use by branch
        rom[14] = immWord(isaPkg::opAddi, 5'd13, 5'd0, randomImm());
        rom[15] = aluWord(isaPkg::aluSub, 5'd14, 5'd1, 5'd1);     // Zero
        rom[16] = immWord(isaPkg::opBeqz, 5'd0, 5'd14, 16'd2);    // Taken
        rom[17] = immWord(isaPkg::opAddi, 5'd15, 5'd0, randomImm());
        rom[18] = immWord(isaPkg::opAddi, 5'd16, 5'd0, randomImm() | 16'h8000);
        rom[19] = immWord(isaPkg::opBltz, 5'd0, 5'd16, 16'd2);    // Taken
        rom[20] = immWord(isaPkg::opAddi, 5'd17, 5'd0, randomImm());
        rom[21] = immWord(isaPkg::opAddi, 5'd18, 5'd0, (randomImm() & 16'h7fff) | 16'h0001);
        rom[22] = immWord(isaPkg::opBeqz, 5'd0, 5'd18, 16'd2);    // Not taken
        rom[23] = immWord(isaPkg::opBltz, 5'd0, 5'd18, 16'd2);    // Not taken
        rom[24] = immWord(isaPkg::opAddi, 5'd19, 5'd18, randomImm());
        rom[25] = jumpWord(26'd4);                                // Over three writers
        rom[26] = immWord(isaPkg::opAddi, 5'd20, 5'd0, randomImm());
        rom[27] = aluWord(isaPkg::aluAdd, 5'd21, 5'd1, 5'd2);
        rom[28] = immWord(isaPkg::opAddi, 5'd22, 5'd0, randomImm());
        rom[29] = aluWord(isaPkg::aluAdd, 5'd23, 5'd19, 5'd16);
        rom[loopIdx] = jumpWord(26'd0);
    endtask

    // ----------------------------------------
    // In-order reference model
    // ----------------------------------------
    function automatic void recordWrite(input logic [4:0] rd, input logic [31:0] val);
        if (rd != '0) begin  // r0 writes are never seen
            modelRegs[rd] = val;
            expDest.push_back(rd);
            expData.push_back(val);
        end
    endfunction

    task automatic runModel();
        isaPkg::instrWordT w;
        logic [31:0] a, b, imm, res, addr;
        logic [25:0] off;
        int          pc, next, steps;
        bit          stop;
        for (int i = 0; i < corePkg::numRegs; i++) begin
            modelRegs[i] = '0;
        end
        for (int i = 0; i < corePkg::dataMemDepth; i++) begin
            modelMem[i] = '0;
        end
        pc    = 0;
        steps = 0;
        stop  = 1'b0;
        while (!stop && steps < 4 * progLen) begin
            w    = rom[pc];
            a    = modelRegs[w.i.rs];
            imm  = {{16{w.i.imm[15]}}, w.i.imm};
            addr = a + imm;
            next = pc + 1;
            case (w.i.opcode)
                isaPkg::opAlu: begin
                    b = modelRegs[w.r.rt];
                    case (w.r.func)
                        isaPkg::aluSub: res = a - b;
                        isaPkg::aluAnd: res = a & b;
                        isaPkg::aluOr:  res = a | b;
                        isaPkg::aluXor: res = a ^ b;
                        isaPkg::aluSlt: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default:        res = a + b;
                    endcase
                    recordWrite(w.r.rd, res);
                end
                isaPkg::opAddi: recordWrite(w.i.rd, a + imm);
                isaPkg::opLw:   recordWrite(w.i.rd, modelMem[addr[9:2]]);
                isaPkg::opSw:   modelMem[addr[9:2]] = modelRegs[w.i.rd];
                isaPkg::opBeqz: if (a == '0) next = pc + int'($signed(w.i.imm));
                isaPkg::opBltz: if (a[31]) next = pc + int'($signed(w.i.imm));
                isaPkg::opJ: begin
                    off  = {w.i.rd, w.i.rs, w.i.imm};
                    stop = (off == '0);  // Self-loop ends the program
                    next = pc + int'($signed(off));
                end
                default: ;
            endcase
            pc = next;
            steps++;
        end
    endtask

    // ----------------------------------------
    // Writeback comparison
    // ----------------------------------------
    always @(negedge clk) begin
        if (rstN && wbEnable) begin
            assert (expDest.size() != 0)
            else begin
                errors++;
                $display("Unexpected writeback to r%0d after the last expected write", wbDest);
            end
            if (expDest.size() != 0) begin
                wbChecked++;
                assert (wbDest == expDest[0])
                else begin
                    errors++;
                    $display("Fail wbDest expected 0x%h actual 0x%h", expDest[0], wbDest);
                end
                assert (wbData == expData[0])
                else begin
                    errors++;
                    $display("Fail wbData expected 0x%h actual 0x%h", expData[0], wbData);
                end
                void'(expDest.pop_front());
                void'(expData.pop_front());
            end
        end
    end

    // Watchdog
    initial begin
        #(timeoutCycles * clkPeriod);
        $display("Run timed out after %0d cycles with %0d writes still expected",
                 timeoutCycles, expDest.size());
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        int total;
        rstN      = 1'b0;
        seed      = 98;
        errors    = 0;
        wbChecked = 0;
        buildProgram();
        runModel();
        repeat (resetCycles) @(posedge clk);
        rstN <= 1'b1;
        while (expDest.size() != 0) @(posedge clk);  // Drained by the compare block
        repeat (settleCycles) begin
            @(negedge clk);
            assert (fetchAddr == loopIdx * 4 || fetchAddr == loopIdx * 4 + 4)
            else begin
                errors++;
                $display("Fail fetchAddr expected 0x%h or 0x%h actual 0x%h",
                         loopIdx * 4, loopIdx * 4 + 4, fetchAddr);
            end
        end
        total = errors + i_pipelineCore.i_checker.assertFails;
        $display("Writebacks checked %0d, testbench errors %0d, assertion failures %0d",
                 wbChecked, errors, i_pipelineCore.i_checker.assertFails);
        if (total == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/pipelineCore_checker.sv
`timescale 1ns/1ns
`default_nettype none

module pipelineCore_checker (
    input wire logic                              clk,
    input wire logic                              rstN,
    input wire logic [corePkg::dataWidth-1:0]     fetchAddr,
    input wire logic                              wbEnable,
    input wire logic [corePkg::regAddrWidth-1:0]  wbDest
);

    int unsigned assertFails = 0;  // Read by the testbench at the end

    // ----------------------------------------
    // Reset behavior
    // ----------------------------------------
    resetQuiet: assert property (@(posedge clk) !rstN |-> !wbEnable && fetchAddr == '0)
        else begin
            assertFails++;
            $error("Writeback or fetch activity while reset is low");
        end

    // First edge out of reset still sees reset state
    firstEdgeQuiet: assert property (@(posedge clk) $rose(rstN) |-> !wbEnable && fetchAddr == '0)
        else begin
            assertFails++;
            $error("Core not in reset state on first edge after reset release");
        end

    // ----------------------------------------
    // Running behavior
    // ----------------------------------------
    noZeroWrite: assert property (@(posedge clk) disable iff (!rstN) wbEnable |-> wbDest != '0)
        else begin
            assertFails++;
            $error("Writeback raised for register 0");
        end

    fetchAligned: assert property (@(posedge clk) !$isunknown(fetchAddr) && fetchAddr[1:0] == 2'b00)
        else begin
            assertFails++;
            $error("Fetch address unknown or not word aligned");
        end

endmodule

bind pipelineCore pipelineCore_checker i_checker (
    .clk       (clk),
    .rstN      (rstN),
    .fetchAddr (fetchAddr),
    .wbEnable  (wbEnable),
    .wbDest    (wbDest)
);

`default_nettype wire

//--- src/pipelineCore.sv
`timescale 1ns/1ns
`default_nettype none

module pipelineCore (
    input  wire logic                              clk,
    input  wire logic                              rstN,
    output logic      [corePkg::dataWidth-1:0]     fetchAddr,
    input  wire isaPkg::instrWordT                 fetchInstr,
    output logic                                   wbEnable,
    output logic      [corePkg::regAddrWidth-1:0]  wbDest,
    output logic      [corePkg::dataWidth-1:0]     wbData
);

    // IF to ID
    isaPkg::instrWordT                 idInstr;
    logic [corePkg::dataWidth-1:0]     idPc, redirectTarget;
    logic                              stall, redirect;
    logic [corePkg::regAddrWidth-1:0]  idRs, idRt;
    corePkg::fwdSelT                   fwdSelA, fwdSelB;

    // ID to EX
    isaPkg::aluFuncT                   exAluOp;
    logic [corePkg::dataWidth-1:0]     exOperandA, exOperandB, exStoreData, exAluResult;
    logic [corePkg::regAddrWidth-1:0]  exDest;
    logic                              exRegWrite, exMemRead, exMemWrite;

    // EX to MEM
    logic [corePkg::dataWidth-1:0]     memAluOut, memStoreData, memResult;
    logic [corePkg::regAddrWidth-1:0]  memDest;
    logic                              memRegWrite, memMemRead, memMemWrite;

    fetchStage i_fetchStage (
        .clk, .rstN, .stall, .redirect, .redirectTarget,
        .fetchAddr, .fetchInstr, .idInstr, .idPc
    );

    hazardUnit i_hazardUnit (
        .idRs, .idRt, .exDest, .exRegWrite, .exMemRead,
        .memDest, .memRegWrite, .wbDest, .wbEnable,
        .fwdSelA, .fwdSelB, .stall
    );

    decodeStage i_decodeStage (
        .clk, .rstN, .idInstr, .idPc, .stall,
        .fwdSelA, .fwdSelB,
        .exAluResult, .memResult, .wbData, .wbEnable, .wbDest,
        .idRs, .idRt, .redirect, .redirectTarget,
        .exAluOp, .exOperandA, .exOperandB, .exStoreData,
        .exDest, .exRegWrite, .exMemRead, .exMemWrite
    );

    executeStage i_executeStage (
        .clk, .rstN, .exAluOp, .exOperandA, .exOperandB, .exStoreData,
        .exDest, .exRegWrite, .exMemRead, .exMemWrite,
        .exAluResult, .memAluOut, .memStoreData,
        .memDest, .memRegWrite, .memMemRead, .memMemWrite
    );

    memoryStage i_memoryStage (
        .clk, .rstN, .memAluOut, .memStoreData,
        .memDest, .memRegWrite, .memMemRead, .memMemWrite,
        .memResult, .wbEnable, .wbDest, .wbData
    );

endmodule

`default_nettype wire

//--- src/memoryStage.sv
`timescale 1ns/1ns
`default_nettype none

module memoryStage (
    input  wire logic                              clk,
    input  wire logic                              rstN,
    input  wire logic [corePkg::dataWidth-1:0]     memAluOut,
    input  wire logic [corePkg::dataWidth-1:0]     memStoreData,
    input  wire logic [corePkg::regAddrWidth-1:0]  memDest,
    input  wire logic                              memRegWrite,
    input  wire logic                              memMemRead,
    input  wire logic                              memMemWrite,
    output logic      [corePkg::dataWidth-1:0]     memResult,
    output logic                                   wbEnable,
    output logic      [corePkg::regAddrWidth-1:0]  wbDest,
    output logic      [corePkg::dataWidth-1:0]     wbData
);

    logic [corePkg::dataWidth-1:0]        dataMem [corePkg::dataMemDepth];
    logic [corePkg::dataMemAddrWidth-1:0] wordIdx;

    assign wordIdx = memAluOut[corePkg::dataMemAddrWidth+1:2];  // Byte address to word

    // Data memory, write on edge
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < corePkg::dataMemDepth; i++) begin
                dataMem[i] <= '0;
            end
        end else if (memMemWrite) begin
            dataMem[wordIdx] <= memStoreData;
        end
    end

    assign memResult = memMemRead ? dataMem[wordIdx] : memAluOut;  // Async read

    // ----------------------------------------
    // MEM/WB register
    // ----------------------------------------
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wbEnable <= 1'b0;
            wbDest   <= '0;
        end else begin
            wbEnable <= memRegWrite && memDest != '0;  // r0 writes dropped here
            wbDest   <= memDest;
        end
    end

    always_ff @(posedge clk) begin
        wbData <= memResult;
    end

endmodule

`default_nettype wire

//--- src/executeStage.sv
`timescale 1ns/1ns
`default_nettype none

module executeStage (
    input  wire logic                              clk,
    input  wire logic                              rstN,
    input  wire isaPkg::aluFuncT                   exAluOp,
    input  wire logic [corePkg::dataWidth-1:0]     exOperandA,
    input  wire logic [corePkg::dataWidth-1:0]     exOperandB,
    input  wire logic [corePkg::dataWidth-1:0]     exStoreData,
    input  wire logic [corePkg::regAddrWidth-1:0]  exDest,
    input  wire logic                              exRegWrite,
    input  wire logic                              exMemRead,
    input  wire logic                              exMemWrite,
    output logic      [corePkg::dataWidth-1:0]     exAluResult,
    output logic      [corePkg::dataWidth-1:0]     memAluOut,
    output logic      [corePkg::dataWidth-1:0]     memStoreData,
    output logic      [corePkg::regAddrWidth-1:0]  memDest,
    output logic                                   memRegWrite,
    output logic                                   memMemRead,
    output logic                                   memMemWrite
);

    // ALU, also feeds EX forwarding
    always_comb begin
        case (exAluOp)
            isaPkg::aluSub: exAluResult = exOperandA - exOperandB;
            isaPkg::aluAnd: exAluResult = exOperandA & exOperandB;
            isaPkg::aluOr:  exAluResult = exOperandA | exOperandB;
            isaPkg::aluXor: exAluResult = exOperandA ^ exOperandB;
            isaPkg::aluSlt: exAluResult = {{(corePkg::dataWidth-1){1'b0}},
                                           $signed(exOperandA) < $signed(exOperandB)};
            default:        exAluResult = exOperandA + exOperandB;  // Add and addresses
        endcase
    end

    // ----------------------------------------
    // EX/MEM register
    // ----------------------------------------
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            memDest     <= '0;
            memRegWrite <= 1'b0;
            memMemRead  <= 1'b0;
            memMemWrite <= 1'b0;
        end else begin
            memDest     <= exDest;
            memRegWrite <= exRegWrite;
            memMemRead  <= exMemRead;
            memMemWrite <= exMemWrite;
        end
    end

    always_ff @(posedge clk) begin
        memAluOut    <= exAluResult;
        memStoreData <= exStoreData;
    end

endmodule

`default_nettype wire

//--- src/decodeStage.sv
`timescale 1ns/1ns
`default_nettype none

module decodeStage (
    input  wire logic                              clk,
    input  wire logic                              rstN,
    input  wire isaPkg::instrWordT                 idInstr,
    input  wire logic [corePkg::dataWidth-1:0]     idPc,
    input  wire logic                              stall,
    input  wire corePkg::fwdSelT                   fwdSelA,
    input  wire corePkg::fwdSelT                   fwdSelB,
    input  wire logic [corePkg::dataWidth-1:0]     exAluResult,
    input  wire logic [corePkg::dataWidth-1:0]     memResult,
    input  wire logic [corePkg::dataWidth-1:0]     wbData,
    input  wire logic                              wbEnable,
    input  wire logic [corePkg::regAddrWidth-1:0]  wbDest,
    output logic      [corePkg::regAddrWidth-1:0]  idRs,
    output logic      [corePkg::regAddrWidth-1:0]  idRt,
    output logic                                   redirect,
    output logic      [corePkg::dataWidth-1:0]     redirectTarget,
    output isaPkg::aluFuncT                        exAluOp,
    output logic      [corePkg::dataWidth-1:0]     exOperandA,
    output logic      [corePkg::dataWidth-1:0]     exOperandB,
    output logic      [corePkg::dataWidth-1:0]     exStoreData,
    output logic      [corePkg::regAddrWidth-1:0]  exDest,
    output logic                                   exRegWrite,
    output logic                                   exMemRead,
    output logic                                   exMemWrite
);

    localparam int W = corePkg::dataWidth;

    isaPkg::opcodeT                    opcode;
    isaPkg::aluFuncT                   aluOp;
    logic [corePkg::regAddrWidth-1:0]  dest;
    logic                              regWrite, memRead, memWrite, useImm;
    logic [W-1:0]                      regDataA, regDataB, srcA, srcB;
    logic [W-1:0]                      immExt, branchOffset, jumpOffset;
    logic                              taken;

    function automatic logic [W-1:0] pickOperand(
        input corePkg::fwdSelT sel,
        input logic [W-1:0]    regVal,
        input logic [W-1:0]    exVal,
        input logic [W-1:0]    memVal,
        input logic [W-1:0]    wbVal
    );
        case (sel)
            corePkg::fwdEx:  pickOperand = exVal;
            corePkg::fwdMem: pickOperand = memVal;
            corePkg::fwdWb:  pickOperand = wbVal;
            default:         pickOperand = regVal;
        endcase
    endfunction

    // ----------------------------------------
    // Control decode
    // ----------------------------------------
    assign opcode = idInstr.i.opcode;  // Same bits in both formats
    assign idRs   = (opcode == isaPkg::opJ) ? '0 : idInstr.i.rs;
    assign idRt   = (opcode == isaPkg::opAlu) ? idInstr.r.rt :
                    (opcode == isaPkg::opSw)  ? idInstr.i.rd : '0;  // Zero means no read

    always_comb begin
        aluOp    = isaPkg::aluAdd;  // Address math for loads and stores
        dest     = '0;
        regWrite = 1'b0;
        memRead  = 1'b0;
        memWrite = 1'b0;
        useImm   = 1'b1;
        case (opcode)
            isaPkg::opAlu: begin
                aluOp    = idInstr.r.func;
                dest     = idInstr.r.rd;
                regWrite = 1'b1;
                useImm   = 1'b0;
            end
            isaPkg::opAddi: begin
                dest     = idInstr.i.rd;
                regWrite = 1'b1;
            end
            isaPkg::opLw: begin
                dest     = idInstr.i.rd;
                regWrite = 1'b1;
                memRead  = 1'b1;
            end
            isaPkg::opSw:  memWrite = 1'b1;
            default:       ;  // Branches and jumps write nothing
        endcase
    end

    registerFile i_registerFile (
        .clk         (clk),
        .rstN        (rstN),
        .readAddrA   (idRs),
        .readAddrB   (idRt),
        .readDataA   (regDataA),
        .readDataB   (regDataB),
        .writeEnable (wbEnable),
        .writeAddr   (wbDest),
        .writeData   (wbData)
    );

    assign srcA = pickOperand(fwdSelA, regDataA, exAluResult, memResult, wbData);
    assign srcB = pickOperand(fwdSelB, regDataB, exAluResult, memResult, wbData);

    // ----------------------------------------
    // Branch resolution
    // ----------------------------------------
    assign immExt       = {{(W-16){idInstr.i.imm[15]}}, idInstr.i.imm};
    assign branchOffset = {immExt[W-3:0], 2'b00};
    assign jumpOffset   = {{(W-28){idInstr.i.rd[4]}}, idInstr.i.rd, idInstr.i.rs,
                           idInstr.i.imm, 2'b00};  // Low 26 bits times four

    always_comb begin
        case (opcode)
            isaPkg::opBeqz: taken = (srcA == '0);  // Zero flag
            isaPkg::opBltz: taken = srcA[W-1];     // Negative flag
            isaPkg::opJ:    taken = 1'b1;
            default:        taken = 1'b0;
        endcase
    end

    assign redirect       = taken && !stall;  // Operand not valid while stalled
    assign redirectTarget = idPc + ((opcode == isaPkg::opJ) ? jumpOffset : branchOffset);

    // ----------------------------------------
    // ID/EX register
    // ----------------------------------------
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            exAluOp    <= isaPkg::aluAdd;
            exDest     <= '0;
            exRegWrite <= 1'b0;
            exMemRead  <= 1'b0;
            exMemWrite <= 1'b0;
        end else begin
            exAluOp    <= stall ? isaPkg::aluAdd : aluOp;  // Bubble on stall
            exDest     <= stall ? '0 : dest;
            exRegWrite <= regWrite && !stall;
            exMemRead  <= memRead && !stall;
            exMemWrite <= memWrite && !stall;
        end
    end

    always_ff @(posedge clk) begin
        exOperandA  <= srcA;
        exOperandB  <= useImm ? immExt : srcB;
        exStoreData <= srcB;
    end

endmodule

`default_nettype wire

//--- src/hazardUnit.sv
`timescale 1ns/1ns
`default_nettype none

module hazardUnit (
    input  wire logic [corePkg::regAddrWidth-1:0]  idRs,
    input  wire logic [corePkg::regAddrWidth-1:0]  idRt,
    input  wire logic [corePkg::regAddrWidth-1:0]  exDest,
    input  wire logic                              exRegWrite,
    input  wire logic                              exMemRead,
    input  wire logic [corePkg::regAddrWidth-1:0]  memDest,
    input  wire logic                              memRegWrite,
    input  wire logic [corePkg::regAddrWidth-1:0]  wbDest,
    input  wire logic                              wbEnable,
    output corePkg::fwdSelT                        fwdSelA,
    output corePkg::fwdSelT                        fwdSelB,
    output logic                                   stall
);

    // Youngest matching producer wins
    function automatic corePkg::fwdSelT pickSource(
        input logic [corePkg::regAddrWidth-1:0] src
    );
        pickSource = corePkg::fwdReg;
        if (src != '0) begin  // r0 never forwarded
            if (exRegWrite && exDest == src) begin
                pickSource = corePkg::fwdEx;
            end else if (memRegWrite && memDest == src) begin
                pickSource = corePkg::fwdMem;
            end else if (wbEnable && wbDest == src) begin
                pickSource = corePkg::fwdWb;
            end
        end
    endfunction

    always_comb begin
        fwdSelA = pickSource(idRs);
        fwdSelB = pickSource(idRt);
    end

    // Load data not ready until MEM
    assign stall = exMemRead && exDest != '0
                   && (exDest == idRs || exDest == idRt);

endmodule

`default_nettype wire

//--- src/registerFile.sv
`timescale 1ns/1ns
`default_nettype none

module registerFile (
    input  wire logic                              clk,
    input  wire logic                              rstN,
    input  wire logic [corePkg::regAddrWidth-1:0]  readAddrA,
    input  wire logic [corePkg::regAddrWidth-1:0]  readAddrB,
    output logic      [corePkg::dataWidth-1:0]     readDataA,
    output logic      [corePkg::dataWidth-1:0]     readDataB,
    input  wire logic                              writeEnable,
    input  wire logic [corePkg::regAddrWidth-1:0]  writeAddr,
    input  wire logic [corePkg::dataWidth-1:0]     writeData
);

    logic [corePkg::dataWidth-1:0] regs [1:corePkg::numRegs-1];  // No storage for r0

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 1; i < corePkg::numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && writeAddr != '0) begin
            regs[writeAddr] <= writeData;
        end
    end

    assign readDataA = (readAddrA == '0) ? '0 : regs[readAddrA];
    assign readDataB = (readAddrB == '0) ? '0 : regs[readAddrB];

endmodule

`default_nettype wire

//--- src/fetchStage.sv
`timescale 1ns/1ns
`default_nettype none

module fetchStage (
    input  wire logic                           clk,
    input  wire logic                           rstN,
    input  wire logic                           stall,
    input  wire logic                           redirect,
    input  wire logic [corePkg::dataWidth-1:0]  redirectTarget,
    output logic      [corePkg::dataWidth-1:0]  fetchAddr,
    input  wire isaPkg::instrWordT              fetchInstr,
    output isaPkg::instrWordT                   idInstr,
    output logic      [corePkg::dataWidth-1:0]  idPc
);

    logic [corePkg::dataWidth-1:0] pc;
    logic [corePkg::dataWidth-1:0] pcPlus4;

    assign pcPlus4   = pc + corePkg::dataWidth'(4);
    assign fetchAddr = pc;  // ROM answers in the same cycle

    // ----------------------------------------
    // PC and IF/ID
    // ----------------------------------------
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc      <= '0;
            idInstr <= isaPkg::instrNop;
            idPc    <= '0;
        end else if (redirect) begin
            pc      <= redirectTarget;
            idInstr <= isaPkg::instrNop;  // Squash fall-through
            idPc    <= pc;
        end else if (!stall) begin
            pc      <= pcPlus4;
            idInstr <= fetchInstr;
            idPc    <= pc;
        end
        // Stall holds PC and IF/ID
    end

endmodule

`default_nettype wire

//--- src/corePkg.sv
`default_nettype none

package corePkg;

    // Datapath sizes
    localparam int dataWidth    = 32;
    localparam int regAddrWidth = 5;
    localparam int numRegs      = 32;

    // Data memory in words
    localparam int dataMemDepth     = 256;
    localparam int dataMemAddrWidth = $clog2(dataMemDepth);

    // Operand source in decode
    typedef enum logic [1:0] {
        fwdReg = 2'd0,  // Register file
        fwdEx  = 2'd1,  // ALU result in EX
        fwdMem = 2'd2,  // Load data or ALU result in MEM
        fwdWb  = 2'd3   // Value being written back
    } fwdSelT;

endpackage

`default_nettype wire

//--- src/isaPkg.sv
`default_nettype none

package isaPkg;

    // Major opcodes, bits 31:26 of every format
    typedef enum logic [5:0] {
        opAlu  = 6'h00,  // Register format
        opAddi = 6'h08,
        opLw   = 6'h23,
        opSw   = 6'h2b,
        opBeqz = 6'h04,
        opBltz = 6'h01,
        opJ    = 6'h02   // Offset in the low 26 bits
    } opcodeT;

    typedef enum logic [3:0] {
        aluAdd = 4'h0,
        aluSub = 4'h1,
        aluAnd = 4'h2,
        aluOr  = 4'h3,
        aluXor = 4'h4,
        aluSlt = 4'h5    // Signed compare
    } aluFuncT;

    typedef struct packed {
        opcodeT      opcode;
        logic [4:0]  rd;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [6:0]  spare;  // Ignored by decode
        aluFuncT     func;
    } rTypeT;

    typedef struct packed {
        opcodeT      opcode;
        logic [4:0]  rd;     // Store data source for opSw
        logic [4:0]  rs;
        logic [15:0] imm;
    } iTypeT;

    // One fetched word seen through either format
    typedef union packed {
        rTypeT r;
        iTypeT i;
    } instrWordT;

    localparam instrWordT instrNop = '0;  // add r0 with r0 and r0

endpackage

`default_nettype wire
